// ==== tb.f ====
uart_pkg.sv
uart_tx.sv
uart_rx.sv
r1_lfsr.sv
trojan1.sv
trojan1_uart_host.sv
tb_trojan1_uart_host.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -f tb.f \
    --top-module tb_trojan1_uart_host --Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^NO ERRORS$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== tb_trojan1_uart_host.sv ====
/* Testbench for trojan1 UART host */
`timescale 1ns/1ps
`default_nettype none

module tb_trojan1_uart_host;
    import uart_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int N_LOOP     = 40;
    localparam int N_BUSY     = 4;
    localparam int N_DIRECT   = 20;
    localparam int N_BAD      = 6;   // Each round is bad stop, glitch and good frame
    localparam int N_FRAMES   = N_LOOP + N_BUSY + N_DIRECT + 3 * N_BAD;

    logic  clk;
    logic  rst;
    data_t tx_data;
    logic  tx_start;
    logic  rx_in;
    data_t rx_data;
    logic  tx_out;
    logic  tx_busy;
    logic  rx_ready;

    logic  loopback;   // rx_in source select
    logic  bang_line;  // Bit-banged serial line
    int    seed;
    data_t exp_q[$];
    int    rx_count;
    int    n_corrupt;
    int    n_clean;

    // Reference model state
    baud_cnt_t  m_baud;
    r1_state_t  m_lfsr;
    logic [1:0] m_phase;
    r1_hist_t   m_hist;
    logic       m_trig;
    logic       m_in_frame;
    logic       m_busy;
    int         m_ticks;
    data_t      m_byte;

    trojan1_uart_host dut_i (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .rx_in    (rx_in),
        .rx_data  (rx_data),
        .tx_out   (tx_out),
        .tx_busy  (tx_busy),
        .rx_ready (rx_ready)
    );

    assign rx_in = loopback ? tx_out : bang_line;

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped on first failure");
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Tap chosen by the phase counter
    function automatic logic r1_tap(input r1_state_t s, input logic [1:0] p);
        case (p)
            2'd0:    return s[0];
            2'd1:    return s[6];
            2'd2:    return s[12];
            default: return s[17];
        endcase
    endfunction

    // Model steps and checks tx_busy and rx_ready at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            m_baud     = '0;
            m_lfsr     = R1_SEED;
            m_phase    = 2'd0;
            m_hist     = '0;
            m_in_frame = 1'b0;
            m_busy     = 1'b0;
            m_ticks    = 0;
        end else begin
            check_bit("tx_busy", tx_busy, m_busy);
            m_busy = m_in_frame || tx_start;  // Idle strobe or frame in flight
            m_trig = (m_hist == TRIGGER_PATTERN);
            if (m_in_frame) begin
                if (m_baud == '0) begin
                    // Tick 0 is the start bit and data bit n goes out at tick n+1
                    if (m_ticks == CORRUPT_BIT + 1) begin
                        exp_q.push_back(m_trig ? m_byte ^ data_t'(1 << CORRUPT_BIT) : m_byte);
                        if (m_trig) n_corrupt++;
                        else n_clean++;
                    end
                    if (m_ticks == DATA_BITS + STOP_BITS) m_in_frame = 1'b0;
                    m_ticks++;
                end
            end else if (tx_start) begin
                m_in_frame = 1'b1;
                m_ticks    = 0;
                m_byte     = tx_data;
            end
            m_hist = {m_hist[2:0], r1_tap(m_lfsr, m_phase)};
            if (tx_start || tx_busy || rx_ready) begin
                m_lfsr  = {m_lfsr[16:0], m_lfsr[17] ^ m_lfsr[10] ^ m_lfsr[2]};
                m_phase = m_phase + 2'd1;
            end
            m_baud = (m_baud == baud_cnt_t'(BAUD_DIV - 1)) ? '0 : m_baud + 1'b1;
            if (rx_ready) begin
                if (exp_q.size() == 0) begin
                    fail_run("rx_ready pulsed while no byte was expected");
                end else begin
                    check_data("rx_data", rx_data, exp_q.pop_front());
                    rx_count++;
                end
            end
        end
    end

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clk);
    endtask

    task automatic pulse_start(input data_t b);
        @(posedge clk);
        tx_start <= 1'b1;
        tx_data  <= b;
        @(posedge clk);
        tx_start <= 1'b0;
    endtask

    task automatic send_loop(input data_t b);
        int target;
        target = rx_count + 1;
        pulse_start(b);
        wait (rx_count == target);
    endtask

    // Extra strobes land between start bit and stop tick
    task automatic send_while_busy(input data_t b);
        int target;
        target = rx_count + 1;
        pulse_start(b);
        wait (tx_out === 1'b0);
        repeat (3) begin
            idle(10 + $unsigned($random(seed)) % 200);
            pulse_start(data_t'($random(seed)));
        end
        wait (rx_count == target);
    endtask

    task automatic drive_bit(input logic v);
        @(posedge clk);
        bang_line <= v;
        idle(BAUD_DIV - 1);
    endtask

    task automatic send_serial(input data_t b, input logic stop);
        drive_bit(1'b0);
        for (int i = 0; i < DATA_BITS; i++) begin
            drive_bit(b[i]);
        end
        drive_bit(stop);
        @(posedge clk);
        bang_line <= 1'b1;
    endtask

    task automatic recv_direct(input data_t b);
        int target;
        target = rx_count + 1;
        exp_q.push_back(b);
        send_serial(b, 1'b1);
        wait (rx_count == target);
        idle(BAUD_DIV);
    endtask

    task automatic send_glitch(input int len);
        @(posedge clk);
        bang_line <= 1'b0;
        idle(len);
        bang_line <= 1'b1;
    endtask

    initial begin : stim
        seed      = 6;
        rst       = 1'b1;
        tx_start  = 1'b0;
        tx_data   = '0;
        loopback  = 1'b0;
        bang_line = 1'b1;
        rx_count  = 0;
        n_corrupt = 0;
        n_clean   = 0;
        idle(4);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("tx_out", tx_out, 1'b1);
        check_bit("tx_busy", tx_busy, 1'b0);
        check_bit("rx_ready", rx_ready, 1'b0);
        check_data("rx_data", rx_data, '0);

        @(posedge clk);
        loopback <= 1'b1;
        for (int i = 0; i < N_LOOP; i++) begin
            send_loop(data_t'($random(seed)));
            idle($unsigned($random(seed)) % (2 * BAUD_DIV));
        end
        for (int i = 0; i < N_BUSY; i++) begin
            send_while_busy(data_t'($random(seed)));
        end
        idle(12 * BAUD_DIV);  // A wrongly accepted strobe would show up here
        @(negedge clk);
        check_bit("tx_busy", tx_busy, 1'b0);

        @(posedge clk);
        loopback <= 1'b0;
        for (int i = 0; i < N_DIRECT; i++) begin
            recv_direct(data_t'($random(seed)));
        end
        for (int i = 0; i < N_BAD; i++) begin
            send_serial(data_t'($random(seed)), 1'b0);
            idle(3 * BAUD_DIV);
            send_glitch(1 + $unsigned($random(seed)) % (HALF_BAUD - 12));
            idle(2 * BAUD_DIV);
            recv_direct(data_t'($random(seed)));
        end

        if (n_corrupt == 0 || n_clean == 0) begin
            fail_run($sformatf("Loopback saw %0d corrupted and %0d clean bytes, need both",
                               n_corrupt, n_clean));
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

    // Watchdog sized from the frame count
    initial begin
        #(longint'(N_FRAMES) * 12 * BAUD_DIV * CLK_PERIOD * 2);
        fail_run("Timeout: the tests did not finish in the allowed time");
    end

endmodule

`default_nettype wire

// ==== trojan1_uart_host.sv ====
/* UART host around trojan1 */
`timescale 1ns/1ps
`default_nettype none

module trojan1_uart_host (
    input  logic            clk,
    input  logic            rst,
    input  uart_pkg::data_t tx_data,
    input  logic            tx_start,
    input  logic            rx_in,
    output uart_pkg::data_t rx_data,
    output logic            tx_out,
    output logic            tx_busy,
    output logic            rx_ready
);
    import uart_pkg::*;

    tx_req_t  tx_req;
    rx_byte_t rx_byte;
    logic     r1;
    logic     trigger;

    assign tx_req.start = tx_start;
    assign tx_req.data  = tx_data;

    uart_tx tx_i (
        .clk     (clk),
        .rst     (rst),
        .tx_req  (tx_req),
        .trigger (trigger),
        .tx_out  (tx_out),
        .tx_busy (tx_busy)
    );

    uart_rx rx_i (
        .clk     (clk),
        .rst     (rst),
        .rx_in   (rx_in),
        .rx_byte (rx_byte)
    );

    assign rx_ready = rx_byte.ready;
    assign rx_data  = rx_byte.data;

    // r1 only moves while the UART is busy
    r1_lfsr r1_i (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .rx_ready (rx_ready),
        .r1       (r1)
    );

    trojan1 trojan_i (
        .clk     (clk),
        .rst     (rst),
        .r1      (r1),
        .trigger (trigger)
    );

endmodule

`default_nettype wire

// ==== trojan1.sv ====
/* Trigger on r1 pattern */
`timescale 1ns/1ps
`default_nettype none

module trojan1 (
    input  logic clk,
    input  logic rst,
    input  logic r1,
    output logic trigger
);
    import uart_pkg::*;

    r1_hist_t hist;

    // Newest sample enters at bit 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist <= '0;
        end else begin
            hist <= {hist[2:0], r1};
        end
    end

    assign trigger = (hist == TRIGGER_PATTERN);  // High for as long as the match holds

endmodule

`default_nettype wire

// ==== r1_lfsr.sv ====
/* Activity-gated r1 generator */
`timescale 1ns/1ps
`default_nettype none

module r1_lfsr (
    input  logic clk,
    input  logic rst,
    input  logic tx_start,
    input  logic tx_busy,
    input  logic rx_ready,
    output logic r1
);
    import uart_pkg::*;

    r1_state_t  lfsr;
    logic [1:0] phase;
    logic       active;

    assign active = tx_start || tx_busy || rx_ready;

    // Fibonacci form with taps 17/10/2 into bit 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr  <= R1_SEED;
            phase <= 2'd0;
        end else if (active) begin
            lfsr  <= {lfsr[16:0], lfsr[17] ^ lfsr[10] ^ lfsr[2]};
            phase <= phase + 2'd1;
        end
    end

    // Phase walks r1 across the register
    always_comb begin
        case (phase)
            2'd0:    r1 = lfsr[0];
            2'd1:    r1 = lfsr[6];
            2'd2:    r1 = lfsr[12];
            default: r1 = lfsr[17];
        endcase
    end

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
/* 8N1 UART receiver */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic               clk,
    input  logic               rst,
    input  logic               rx_in,
    output uart_pkg::rx_byte_t rx_byte
);
    import uart_pkg::*;

    logic [1:0] sync_q;
    logic       rx_s;
    rx_state_t  state;
    baud_cnt_t  timer;
    bit_idx_t   bit_idx;
    data_t      shift_q;
    rx_byte_t   out_q;
    logic       sample;

    // Two-flop synchronizer that idles high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], rx_in};
        end
    end

    assign rx_s = sync_q[1];

    // Timer expiry marks the middle of a bit
    assign sample = (state != RX_IDLE) && (timer == '0);

    always_ff @(posedge clk) begin
        if (sample && (state == RX_DATA)) begin
            shift_q <= {rx_s, shift_q[DATA_BITS-1:1]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= RX_IDLE;
            timer   <= '0;
            bit_idx <= '0;
            out_q   <= '0;
        end else begin
            out_q.ready <= 1'b0;
            if (state != RX_IDLE && !sample) begin
                timer <= timer - 1'b1;
            end
            case (state)
                RX_IDLE: begin
                    if (!rx_s) begin
                        timer <= baud_cnt_t'(HALF_BAUD);
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (sample) begin
                        timer <= baud_cnt_t'(BAUD_DIV - 1);
                        if (!rx_s) begin
                            bit_idx <= '0;
                            state   <= RX_DATA;
                        end else begin
                            state <= RX_IDLE;  // Line back high means a glitch
                        end
                    end
                end
                RX_DATA: begin
                    if (sample) begin
                        timer <= baud_cnt_t'(BAUD_DIV - 1);
                        if (bit_idx == bit_idx_t'(DATA_BITS - 1)) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                RX_STOP: begin
                    if (sample) begin
                        if (rx_s) begin
                            out_q.data  <= shift_q;
                            out_q.ready <= 1'b1;
                        end
                        state <= RX_IDLE;  // Bad stop bit drops the byte
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    assign rx_byte = out_q;

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
/* 8N1 UART transmitter */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic              clk,
    input  logic              rst,
    input  uart_pkg::tx_req_t tx_req,
    input  logic              trigger,
    output logic              tx_out,
    output logic              tx_busy
);
    import uart_pkg::*;

    baud_cnt_t baud_cnt;
    tx_state_t state;
    bit_idx_t  bit_idx;
    data_t     shift_q;
    logic      baud_tick;
    logic      load;
    logic      shift;

    // Free-running divider that ticks on zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            baud_cnt <= '0;
        end else if (baud_cnt == baud_cnt_t'(BAUD_DIV - 1)) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    assign baud_tick = (baud_cnt == '0);
    assign load      = (state == TX_IDLE) && tx_req.start;
    assign shift     = (state == TX_DATA) && baud_tick;

    // LSB leaves first
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= tx_req.data;
        end else if (shift) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= TX_IDLE;
            tx_out  <= 1'b1;
            tx_busy <= 1'b0;
            bit_idx <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    tx_out  <= 1'b1;
                    tx_busy <= tx_req.start;  // Falls one cycle after the stop tick
                    if (tx_req.start) begin
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (baud_tick) begin
                        tx_out  <= 1'b0;
                        bit_idx <= '0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (baud_tick) begin
                        // Inversion point for the trigger
                        tx_out <= shift_q[0] ^
                                  (trigger && (bit_idx == bit_idx_t'(CORRUPT_BIT)));
                        if (bit_idx == bit_idx_t'(DATA_BITS - 1)) begin
                            bit_idx <= '0;
                            state   <= TX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                TX_STOP: begin
                    if (baud_tick) begin
                        tx_out <= 1'b1;
                        if (bit_idx == bit_idx_t'(STOP_BITS - 1)) begin
                            state <= TX_IDLE;  // Last stop bit runs out in idle
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== uart_pkg.sv ====
/* UART host shared definitions */
`default_nettype none

package uart_pkg;

    // Frame format and bit timing
    localparam int BAUD_DIV  = 104;  // About 480 kbaud from a 50 MHz clock
    localparam int HALF_BAUD = 52;   // Start edge to mid-bit
    localparam int DATA_BITS = 8;
    localparam int STOP_BITS = 1;

    // Data bit hit by the trigger
    localparam int CORRUPT_BIT = 3;

    typedef logic [DATA_BITS-1:0] data_t;
    typedef logic [15:0]          baud_cnt_t;
    typedef logic [3:0]           bit_idx_t;
    typedef logic [17:0]          r1_state_t;
    typedef logic [3:0]           r1_hist_t;

    localparam r1_state_t R1_SEED = 18'h2CAFE;

    // Newest r1 sample sits in bit 0
    localparam r1_hist_t TRIGGER_PATTERN = 4'b1011;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    typedef struct packed {
        logic  start;  // One-cycle send strobe
        data_t data;
    } tx_req_t;

    typedef struct packed {
        logic  ready;  // One-cycle byte valid
        data_t data;
    } rx_byte_t;

endpackage

`default_nettype wire
